// File: armCtrl.f
+incdir+design
design/armCtrlPkg.sv
design/decodeIf.sv
design/decodeUnit.sv
design/aluDecoder.sv
design/condUnit.sv
design/controller.sv
design/armCtrlTop.sv
sim/armCtrlTb.sv

// File: design/aluDecoder.sv
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_defines.svh"

module aluDecoder import armCtrlPkg::*; (
  input  logic              aluOpE,
  input  dpOpT              aluControlE,
  input  logic              prevCarry,
  input  logic              prevOverflow,
  output aluFuncT           aluOperationE,
  output logic              invertBE,
  output logic              reverseInputsE,
  output logic              aluCarryE,
  output logic              doNotWriteRegE,
  output logic [`SRC_W-1:0] cvUpdateE
);

  always_comb begin
    aluOperationE  = aluAdd;
    invertBE       = 1'b0;
    reverseInputsE = 1'b0;
    aluCarryE      = 1'b0;
    doNotWriteRegE = 1'b0;
    cvUpdateE      = 2'b00;
    if (aluOpE) begin
      case (aluControlE)
        opAnd: aluOperationE = aluAnd;
        opEor: aluOperationE = aluXor;
        opOrr: aluOperationE = aluOr;
        opMov: aluOperationE = aluPassB;
        opTst: begin
          aluOperationE  = aluAnd;
          doNotWriteRegE = 1'b1;
        end
        opTeq: begin
          aluOperationE  = aluXor;
          doNotWriteRegE = 1'b1;
        end
        opBic: begin
          aluOperationE = aluAnd;
          invertBE      = 1'b1;
        end
        opMvn: begin
          aluOperationE = aluPassB;
          invertBE      = 1'b1;
        end
        opAdd: cvUpdateE = 2'b11;
        opCmn: begin
          cvUpdateE      = 2'b11;
          doNotWriteRegE = 1'b1;
        end
        opAdc: begin
          aluCarryE = prevCarry;
          cvUpdateE = 2'b11;
        end
        opSub, opCmp: begin
          invertBE       = 1'b1;  // A + ~B + 1
          aluCarryE      = 1'b1;
          cvUpdateE      = 2'b11;
          doNotWriteRegE = (aluControlE == opCmp);
        end
        opRsb: begin
          reverseInputsE = 1'b1;
          invertBE       = 1'b1;
          aluCarryE      = 1'b1;
          cvUpdateE      = 2'b11;
        end
        opSbc, opRsc: begin
          reverseInputsE = (aluControlE == opRsc);
          invertBE       = 1'b1;
          aluCarryE      = prevCarry;
          cvUpdateE      = 2'b11;
        end
        default: ;
      endcase
    end
  end

  // Stored C/V come from the flag register and must be settled once Execute is live
  always_comb begin
    assert (aluOpE !== 1'b1 || !$isunknown({prevCarry, prevOverflow}))
      else $error("aluDecoder: stored C/V unknown with a live ALU op");
  end

endmodule

`default_nettype wire

// File: design/armCtrlPkg.sv
`default_nettype none
`include "armCtrl_defines.svh"

package armCtrlPkg;

  // Instruction class from bits 27:26
  typedef enum logic [1:0] {
    clsDataProc    = 2'b00,
    clsLoadStore   = 2'b01,
    clsBranch      = 2'b10,
    clsUnsupported = 2'b11
  } instrClassT;

  // Data-processing opcode, bits 24:21
  typedef enum logic [3:0] {
    opAnd = 4'h0, opEor = 4'h1, opSub = 4'h2, opRsb = 4'h3,
    opAdd = 4'h4, opAdc = 4'h5, opSbc = 4'h6, opRsc = 4'h7,
    opTst = 4'h8, opTeq = 4'h9, opCmp = 4'hA, opCmn = 4'hB,
    opOrr = 4'hC, opMov = 4'hD, opBic = 4'hE, opMvn = 4'hF
  } dpOpT;

  typedef enum logic [2:0] {
    aluAdd   = 3'd0,
    aluAnd   = 3'd1,
    aluOr    = 3'd2,
    aluXor   = 3'd3,
    aluPassB = 3'd4
  } aluFuncT;

  // Condition field, bits 31:28
  typedef enum logic [`COND_W-1:0] {
    condEq = 4'h0, condNe = 4'h1, condCs = 4'h2, condCc = 4'h3,
    condMi = 4'h4, condPl = 4'h5, condVs = 4'h6, condVc = 4'h7,
    condHi = 4'h8, condLs = 4'h9, condGe = 4'hA, condLt = 4'hB,
    condGt = 4'hC, condLe = 4'hD, condAl = 4'hE, condNv = 4'hF
  } condT;

endpackage

`default_nettype wire

// File: design/armCtrlTop.sv
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_defines.svh"

module armCtrlTop import armCtrlPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [`INSTR_W-1:0] instrD,
  input  logic [`FLAG_W-1:0]  flagsE,   // From the datapath ALU
  input  logic                stallE,
  input  logic                flushE,
  input  logic                stallM,
  input  logic                stallW,
  input  logic                flushW,
  output logic [`SRC_W-1:0]   regSrcD,
  output logic [`SRC_W-1:0]   immSrcD,
  output logic                aluSrcE,
  output logic                branchTakenE,
  output dpOpT                aluControlE,
  output aluFuncT             aluOperationE,
  output logic [`SRC_W-1:0]   cvUpdateE,
  output logic                invertBE,
  output logic                reverseInputsE,
  output logic                aluCarryE,
  output logic                memtoRegE,
  output logic [`FLAG_W-1:0]  previousFlagsE,
  output logic [`INSTR_W-1:0] instrE,
  output logic                memWriteM,
  output logic                memtoRegM,
  output logic                regWriteM,
  output logic                memtoRegW,
  output logic                regWriteW,
  output logic                pcSrcW,
  output logic                pcWrPendingF  // To the hazard unit
);

  controller u_ctrl (.*);

endmodule

`default_nettype wire

// File: design/armCtrl_defines.svh
`ifndef ARMCTRL_DEFINES_SVH
`define ARMCTRL_DEFINES_SVH

// Architectural widths
`define INSTR_W 32
`define FLAG_W  4   // NZCV
`define COND_W  4

// Two-bit control fields (register/immediate source, flag write mask)
`define SRC_W   2

`endif

// File: design/condUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_defines.svh"

module condUnit import armCtrlPkg::*; (
  input  logic               clk,
  input  logic               rst,
  input  logic               stallE,
  input  condT               condE,
  input  logic [`SRC_W-1:0]  flagWriteE,
  input  logic [`FLAG_W-1:0] flagsE,
  output logic               condExE,
  output logic [`FLAG_W-1:0] previousFlagsE
);

  logic [`FLAG_W-1:0] flagsQ;  // NZCV
  logic               n, z, c, v;

  assign {n, z, c, v}   = flagsQ;
  assign previousFlagsE = flagsQ;

  always_comb begin
    case (condE)
      condEq:  condExE = z;
      condNe:  condExE = ~z;
      condCs:  condExE = c;
      condCc:  condExE = ~c;
      condMi:  condExE = n;
      condPl:  condExE = ~n;
      condVs:  condExE = v;
      condVc:  condExE = ~v;
      condHi:  condExE = c & ~z;
      condLs:  condExE = ~c | z;
      condGe:  condExE = (n == v);
      condLt:  condExE = (n != v);
      condGt:  condExE = ~z & (n == v);
      condLe:  condExE = z | (n != v);
      condAl:  condExE = 1'b1;
      default: condExE = 1'b0;  // NV never executes
    endcase
  end

  // Only an instruction that passes its own condition may set flags
  always_ff @(posedge clk) begin
    if (rst) begin
      flagsQ <= '0;
    end else if (!stallE && condExE) begin
      if (flagWriteE[1]) flagsQ[3:2] <= flagsE[3:2];  // N, Z
      if (flagWriteE[0]) flagsQ[1:0] <= flagsE[1:0];  // C, V
    end
  end

  flagsHoldOnStall: assert property (@(posedge clk) disable iff (rst)
    stallE |=> $stable(flagsQ))
    else $error("condUnit: flags changed while Execute was stalled");

endmodule

`default_nettype wire

// File: design/controller.sv
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_defines.svh"

module controller import armCtrlPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic [`INSTR_W-1:0] instrD,
  input  logic [`FLAG_W-1:0]  flagsE,
  input  logic                stallE,
  input  logic                flushE,
  input  logic                stallM,
  input  logic                stallW,
  input  logic                flushW,
  output logic [`SRC_W-1:0]   regSrcD,
  output logic [`SRC_W-1:0]   immSrcD,
  output logic                aluSrcE,
  output logic                branchTakenE,
  output dpOpT                aluControlE,
  output aluFuncT             aluOperationE,
  output logic [`SRC_W-1:0]   cvUpdateE,
  output logic                invertBE,
  output logic                reverseInputsE,
  output logic                aluCarryE,
  output logic                memtoRegE,
  output logic [`FLAG_W-1:0]  previousFlagsE,
  output logic [`INSTR_W-1:0] instrE,
  output logic                memWriteM,
  output logic                memtoRegM,
  output logic                regWriteM,
  output logic                memtoRegW,
  output logic                regWriteW,
  output logic                pcSrcW,
  output logic                pcWrPendingF
);

  logic              aluOpE, regWriteE, memWriteE, branchE, pcSrcE;
  logic [`SRC_W-1:0] flagWriteE;
  logic              condExE, doNotWriteRegE;
  logic              regWriteGatedE, memWriteGatedE, pcSrcGatedE;
  logic              pcSrcM;
  condT              condE;

  decodeIf dIf ();

  decodeUnit u_decode (.instrD(instrD), .ctrl(dIf.decoder));

  assign regSrcD = dIf.regSrc;
  assign immSrcD = dIf.immSrc;

  // Execute register, flush wins over stall
  always_ff @(posedge clk) begin
    if (rst || flushE) begin
      aluSrcE     <= 1'b0;
      memtoRegE   <= 1'b0;
      regWriteE   <= 1'b0;
      memWriteE   <= 1'b0;
      branchE     <= 1'b0;
      aluOpE      <= 1'b0;
      aluControlE <= opAnd;
      flagWriteE  <= '0;
      pcSrcE      <= 1'b0;
      instrE      <= '0;
    end else if (!stallE) begin
      aluSrcE     <= dIf.aluSrc;
      memtoRegE   <= dIf.memtoReg;
      regWriteE   <= dIf.regWrite;
      memWriteE   <= dIf.memWrite;
      branchE     <= dIf.branch;
      aluOpE      <= dIf.aluOp;
      aluControlE <= dIf.aluControl;
      flagWriteE  <= dIf.flagWrite;
      pcSrcE      <= dIf.pcSrc;
      instrE      <= instrD;
    end
  end

  assign condE = condT'(instrE[`INSTR_W-1 -: `COND_W]);

  aluDecoder u_aluDec (
    .aluOpE(aluOpE), .aluControlE(aluControlE),
    .prevCarry(previousFlagsE[1]), .prevOverflow(previousFlagsE[0]),
    .aluOperationE(aluOperationE), .invertBE(invertBE),
    .reverseInputsE(reverseInputsE), .aluCarryE(aluCarryE),
    .doNotWriteRegE(doNotWriteRegE), .cvUpdateE(cvUpdateE)
  );

  condUnit u_cond (
    .clk(clk), .rst(rst), .stallE(stallE), .condE(condE),
    .flagWriteE(flagWriteE), .flagsE(flagsE),
    .condExE(condExE), .previousFlagsE(previousFlagsE)
  );

  assign branchTakenE   = branchE & condExE;
  assign memWriteGatedE = memWriteE & condExE;
  assign regWriteGatedE = regWriteE & condExE & ~doNotWriteRegE;  // TST/TEQ/CMP/CMN
  assign pcSrcGatedE    = pcSrcE & condExE & ~doNotWriteRegE;

  // Memory register
  always_ff @(posedge clk) begin
    if (rst) begin
      memWriteM <= 1'b0;
      memtoRegM <= 1'b0;
      regWriteM <= 1'b0;
      pcSrcM    <= 1'b0;
    end else if (!stallM) begin
      memWriteM <= memWriteGatedE;
      memtoRegM <= memtoRegE;
      regWriteM <= regWriteGatedE;
      pcSrcM    <= pcSrcGatedE;
    end
  end

  // Writeback register
  always_ff @(posedge clk) begin
    if (rst || flushW) begin
      memtoRegW <= 1'b0;
      regWriteW <= 1'b0;
      pcSrcW    <= 1'b0;
    end else if (!stallW) begin
      memtoRegW <= memtoRegM;
      regWriteW <= regWriteM;
      pcSrcW    <= pcSrcM;
    end
  end

  // Decode and Execute terms are ungated, a prediction for the hazard unit
  assign pcWrPendingF = dIf.pcSrc | pcSrcE | pcSrcM;

  storeNeverLoads: assert property (@(posedge clk) disable iff (rst)
    !(memWriteM && regWriteM && memtoRegM))
    else $error("controller: store and load both active in Memory");

endmodule

`default_nettype wire

// File: design/decodeIf.sv
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_defines.svh"

interface decodeIf import armCtrlPkg::*;;

  logic [`SRC_W-1:0] regSrc;
  logic [`SRC_W-1:0] immSrc;
  logic              aluSrc;
  logic              memtoReg;
  logic              regWrite;
  logic              memWrite;
  logic              branch;
  logic              aluOp;      // Route aluControl through the ALU decoder
  dpOpT              aluControl;
  logic [`SRC_W-1:0] flagWrite;  // Bit 1 NZ, bit 0 CV
  logic              pcSrc;

  modport decoder (
    output regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite,
           branch, aluOp, aluControl, flagWrite, pcSrc
  );

  modport pipe (
    input regSrc, immSrc, aluSrc, memtoReg, regWrite, memWrite,
          branch, aluOp, aluControl, flagWrite, pcSrc
  );

endinterface

`default_nettype wire

// File: design/decodeUnit.sv
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_defines.svh"

module decodeUnit import armCtrlPkg::*; (
  input  logic [`INSTR_W-1:0] instrD,
  decodeIf.decoder            ctrl
);

  instrClassT cls;
  logic       immForm;   // Bit 25
  logic       loadBit;   // L bit, bit 20
  logic       upBit;     // U bit, bit 23

  assign cls     = instrClassT'(instrD[27:26]);
  assign immForm = instrD[25];
  assign loadBit = instrD[20];
  assign upBit   = instrD[23];

  always_comb begin
    // Unsupported classes fall out as an all-zero word
    ctrl.regSrc     = 2'b00;
    ctrl.immSrc     = 2'b00;
    ctrl.aluSrc     = 1'b0;
    ctrl.memtoReg   = 1'b0;
    ctrl.regWrite   = 1'b0;
    ctrl.memWrite   = 1'b0;
    ctrl.branch     = 1'b0;
    ctrl.aluOp      = 1'b0;
    ctrl.aluControl = opAnd;
    ctrl.flagWrite  = 2'b00;
    case (cls)
      clsDataProc: begin
        ctrl.aluSrc     = immForm;
        ctrl.regWrite   = 1'b1;
        ctrl.aluOp      = 1'b1;
        ctrl.aluControl = dpOpT'(instrD[24:21]);
        ctrl.flagWrite  = {2{instrD[20]}};  // S bit
      end
      clsLoadStore: begin
        // Immediate offset when bit 25 is clear
        ctrl.immSrc     = immForm ? 2'b00 : 2'b01;
        ctrl.aluSrc     = ~immForm;
        ctrl.regSrc     = loadBit ? 2'b00 : 2'b10;  // STR reads Rd as data
        ctrl.memtoReg   = loadBit;
        ctrl.regWrite   = loadBit;
        ctrl.memWrite   = ~loadBit;
        // Address add/subtract also goes through the ALU decoder
        ctrl.aluOp      = 1'b1;
        ctrl.aluControl = upBit ? opAdd : opSub;
      end
      clsBranch: begin
        ctrl.regSrc     = 2'b01;
        ctrl.immSrc     = 2'b10;
        ctrl.aluSrc     = 1'b1;
        ctrl.branch     = 1'b1;
        ctrl.aluControl = opAdd;  // PC + offset
      end
      default: ;
    endcase
    // Branch, or any write landing in R15
    ctrl.pcSrc = ctrl.branch | (ctrl.regWrite & (instrD[15:12] == 4'hF));
  end

  // Multiply, coprocessor and SWI encodings must not reach this core
  always_comb begin
    assert (cls !== clsUnsupported)
      else $error("decodeUnit: unsupported instruction class %h", instrD);
  end

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the armCtrl testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG"

verilator --binary --timing --assert --top-module armCtrlTb \
  -f armCtrl.f -o armCtrlSim \
  && ./obj_dir/armCtrlSim > "$LOG" 2>&1 \
  || echo "Build or simulation stopped with an error" >> "$LOG"

cat "$LOG"

grep -qx "Simulation PASSED" "$LOG" \
  && echo "Result: pass" \
  && exit 0 \
  || { echo "Result: fail"; exit 1; }

// File: sim/armCtrlTb.sv
`timescale 1ns/1ps
`default_nettype none
`include "armCtrl_defines.svh"

module armCtrlTb import armCtrlPkg::*; ();

  localparam logic [1:0] modeNone  = 2'd0;
  localparam logic [1:0] modeStall = 2'd1;  // stallE held for one cycle in Execute
  localparam logic [1:0] modeFlush = 2'd2;  // flushE with the instruction in Decode
  localparam logic [31:0] filler   = 32'h0000_0000;  // ANDEQ r0, no S

  typedef struct packed {
    logic [`INSTR_W-1:0] word;
    logic [`FLAG_W-1:0]  flags;
    logic [1:0]          mode;
    logic [`SRC_W-1:0]   regSrc;
    logic [`SRC_W-1:0]   immSrc;
    dpOpT                aluCtl;
    aluFuncT             aluFn;
    logic [1:0]          invRev;  // invertB, reverseInputs
    logic                dnw;
    logic [4:0]          wr;      // pendD, branchTaken, memWriteM, regWriteW, pcSrcW
  } testT;

  logic clk, rst;
  logic [`INSTR_W-1:0] instrD, instrE;
  logic [`FLAG_W-1:0]  flagsE, previousFlagsE;
  logic stallE, flushE, stallM, stallW, flushW;
  logic [`SRC_W-1:0] regSrcD, immSrcD, cvUpdateE;
  logic aluSrcE, branchTakenE, invertBE, reverseInputsE, aluCarryE, memtoRegE;
  logic memWriteM, memtoRegM, regWriteM, memtoRegW, regWriteW, pcSrcW, pcWrPendingF;
  dpOpT    aluControlE;
  aluFuncT aluOperationE;

  testT              tests[$];
  logic              tableReady = 1'b0;
  logic [31:0]       rngState = 32'd96505;
  logic [`FLAG_W-1:0] modelFlags = '0;  // NZCV as the flag register should hold it
  int                checks = 0;
  int                errors = 0;

  armCtrlTop dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  function automatic logic [31:0] xorshift();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
  endfunction

  // ARM condition rules against NZCV
  function automatic logic condHolds(input logic [3:0] cond, input logic [3:0] f);
    logic n, z, c, v;
    logic base;
    {n, z, c, v} = f;
    // Odd codes are the inverse of the even code below them
    case (cond[3:1])
      3'd0: base = z;
      3'd1: base = c;
      3'd2: base = n;
      3'd3: base = v;
      3'd4: base = c & ~z;
      3'd5: base = (n == v);
      3'd6: base = ~z & (n == v);
      default: base = 1'b1;  // AL
    endcase
    return (cond == 4'hF) ? 1'b0 : (base ^ cond[0]);
  endfunction

  task automatic addTest(input logic [31:0] word, input logic [3:0] flags,
                         input logic [1:0] mode, input logic [1:0] regSrc,
                         input logic [1:0] immSrc, input dpOpT aluCtl, input aluFuncT aluFn,
                         input logic [1:0] invRev, input logic dnw, input logic [4:0] wr);
    testT t;
    t = '{word, flags, mode, regSrc, immSrc, aluCtl, aluFn, invRev, dnw, wr};
    tests.push_back(t);
  endtask

  task automatic buildTable();
    addTest(32'hE2801000, 4'h0, modeNone, 2'b00, 2'b00, opAdd, aluAdd, 2'b00, 0, 5'b00010);
    // All 16 opcodes, register form, AL, Rd = r2
    addTest(32'hE0002000, 4'h0, modeNone, 2'b00, 2'b00, opAnd, aluAnd, 2'b00, 0, 5'b00010);
    addTest(32'hE0202000, 4'h0, modeNone, 2'b00, 2'b00, opEor, aluXor, 2'b00, 0, 5'b00010);
    addTest(32'hE0402000, 4'h0, modeNone, 2'b00, 2'b00, opSub, aluAdd, 2'b10, 0, 5'b00010);
    addTest(32'hE0602000, 4'h0, modeNone, 2'b00, 2'b00, opRsb, aluAdd, 2'b11, 0, 5'b00010);
    addTest(32'hE0802000, 4'h0, modeNone, 2'b00, 2'b00, opAdd, aluAdd, 2'b00, 0, 5'b00010);
    addTest(32'hE0A02000, 4'h0, modeNone, 2'b00, 2'b00, opAdc, aluAdd, 2'b00, 0, 5'b00010);
    addTest(32'hE0C02000, 4'h0, modeNone, 2'b00, 2'b00, opSbc, aluAdd, 2'b10, 0, 5'b00010);
    addTest(32'hE0E02000, 4'h0, modeNone, 2'b00, 2'b00, opRsc, aluAdd, 2'b11, 0, 5'b00010);
    addTest(32'hE1002000, 4'h0, modeNone, 2'b00, 2'b00, opTst, aluAnd, 2'b00, 1, 5'b00000);
    addTest(32'hE1202000, 4'h0, modeNone, 2'b00, 2'b00, opTeq, aluXor, 2'b00, 1, 5'b00000);
    addTest(32'hE1402000, 4'h0, modeNone, 2'b00, 2'b00, opCmp, aluAdd, 2'b10, 1, 5'b00000);
    addTest(32'hE1602000, 4'h0, modeNone, 2'b00, 2'b00, opCmn, aluAdd, 2'b00, 1, 5'b00000);
    addTest(32'hE1802000, 4'h0, modeNone, 2'b00, 2'b00, opOrr, aluOr, 2'b00, 0, 5'b00010);
    addTest(32'hE1A02000, 4'h0, modeNone, 2'b00, 2'b00, opMov, aluPassB, 2'b00, 0, 5'b00010);
    addTest(32'hE1C02000, 4'h0, modeNone, 2'b00, 2'b00, opBic, aluAnd, 2'b10, 0, 5'b00010);
    addTest(32'hE1E02000, 4'h0, modeNone, 2'b00, 2'b00, opMvn, aluPassB, 2'b10, 0, 5'b00010);
    // Loads, stores, branch
    addTest(32'hE5903000, 4'h0, modeNone, 2'b00, 2'b01, opAdd, aluAdd, 2'b00, 0, 5'b00010);
    addTest(32'hE5103000, 4'h0, modeNone, 2'b00, 2'b01, opSub, aluAdd, 2'b10, 0, 5'b00010);
    addTest(32'hE5804000, 4'h0, modeNone, 2'b10, 2'b01, opAdd, aluAdd, 2'b00, 0, 5'b00100);
    addTest(32'hE7903000, 4'h0, modeNone, 2'b00, 2'b00, opAdd, aluAdd, 2'b00, 0, 5'b00010);
    addTest(32'hEA000000, 4'h0, modeNone, 2'b01, 2'b10, opAdd, aluAdd, 2'b00, 0, 5'b11001);
    // CMP sets Z, then EQ/NE pairs
    addTest(32'hE1500000, 4'h4, modeNone, 2'b00, 2'b00, opCmp, aluAdd, 2'b10, 1, 5'b00000);
    addTest(32'h00802000, 4'h0, modeNone, 2'b00, 2'b00, opAdd, aluAdd, 2'b00, 0, 5'b00010);
    addTest(32'h10802000, 4'h0, modeNone, 2'b00, 2'b00, opAdd, aluAdd, 2'b00, 0, 5'b00000);
    addTest(32'h0A000000, 4'h0, modeNone, 2'b01, 2'b10, opAdd, aluAdd, 2'b00, 0, 5'b11001);
    addTest(32'h1A000000, 4'h0, modeNone, 2'b01, 2'b10, opAdd, aluAdd, 2'b00, 0, 5'b10000);
    addTest(32'h15804000, 4'h0, modeNone, 2'b10, 2'b01, opAdd, aluAdd, 2'b00, 0, 5'b00000);
    addTest(32'hE1500000, 4'h0, modeNone, 2'b00, 2'b00, opCmp, aluAdd, 2'b10, 1, 5'b00000);
    addTest(32'h10802000, 4'h0, modeNone, 2'b00, 2'b00, opAdd, aluAdd, 2'b00, 0, 5'b00010);
    addTest(32'h00802000, 4'h0, modeNone, 2'b00, 2'b00, opAdd, aluAdd, 2'b00, 0, 5'b00000);
    // Writes to r15
    addTest(32'hE1A0F000, 4'h0, modeNone, 2'b00, 2'b00, opMov, aluPassB, 2'b00, 0, 5'b10011);
    addTest(32'hE590F000, 4'h0, modeNone, 2'b00, 2'b01, opAdd, aluAdd, 2'b00, 0, 5'b10011);
    addTest(32'h01A0F000, 4'h0, modeNone, 2'b00, 2'b00, opMov, aluPassB, 2'b00, 0, 5'b10000);
    // Stall and flush
    addTest(32'hE2901000, 4'hA, modeStall, 2'b00, 2'b00, opAdd, aluAdd, 2'b00, 0, 5'b00010);
    addTest(32'hE0802000, 4'h0, modeFlush, 2'b00, 2'b00, opAnd, aluAdd, 2'b00, 0, 5'b00000);
    addTest(32'hE5804000, 4'h0, modeFlush, 2'b10, 2'b01, opAnd, aluAdd, 2'b00, 0, 5'b00000);
    addTest(32'hE0502000, 4'h5, modeFlush, 2'b00, 2'b00, opAnd, aluAdd, 2'b00, 0, 5'b00000);
    addTest(32'hEA000000, 4'h0, modeStall, 2'b01, 2'b10, opAdd, aluAdd, 2'b00, 0, 5'b11001);
  endtask

  task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        $display("[FAIL] %0t ns %s got %0h expected %0h", $time, name, got, exp);
        errors++;
      end
  endtask

  task automatic checkExecute(input testT t, input logic [31:0] word, input logic flush,
                              input logic load);
    logic routed;  // Opcode reaches the ALU decoder
    logic arith;
    logic carry;
    logic immB;
    routed = !flush && (word[27:26] != 2'b10);
    arith  = t.aluCtl inside {opSub, opRsb, opAdd, opAdc, opSbc, opRsc, opCmp, opCmn};
    carry  = (t.aluCtl inside {opSub, opRsb, opCmp}) ||
             ((t.aluCtl inside {opAdc, opSbc, opRsc}) && modelFlags[1]);  // Stored C
    case (word[27:26])
      2'b00:   immB = word[25];   // Immediate operand 2
      2'b01:   immB = ~word[25];  // Immediate offset
      default: immB = 1'b1;       // Branch offset
    endcase
    checkVal("aluControlE", 32'(aluControlE), 32'(t.aluCtl));
    checkVal("aluOperationE", 32'(aluOperationE), 32'(t.aluFn));
    checkVal("invertBE", 32'(invertBE), 32'(t.invRev[1]));
    checkVal("reverseInputsE", 32'(reverseInputsE), 32'(t.invRev[0]));
    checkVal("doNotWriteRegE", 32'(dut0.u_ctrl.doNotWriteRegE), 32'(t.dnw));
    checkVal("branchTakenE", 32'(branchTakenE), 32'(t.wr[3]));
    checkVal("aluSrcE", 32'(aluSrcE), 32'(immB & ~flush));
    checkVal("cvUpdateE", 32'(cvUpdateE), (routed && arith) ? 32'd3 : 32'd0);
    checkVal("aluCarryE", 32'(aluCarryE), 32'(routed && carry));
    checkVal("memtoRegE", 32'(memtoRegE), 32'(load));
    checkVal("instrE", instrE, flush ? 32'd0 : word);
  endtask

  task automatic runTest(input int idx);
    testT        t;
    logic [31:0] word;
    logic        stall;
    logic        flush;
    logic        load;
    int          errBefore;
    t = tests[idx];
    errBefore = errors;
    stall = (t.mode == modeStall);
    flush = (t.mode == modeFlush);
    // Random Rn and operand bits, or a random branch offset
    word = t.word | (xorshift() & ((t.word[27:26] == 2'b10) ? 32'h00FF_FFFF : 32'h000F_0FFF));
    load = !flush && (word[27:26] == 2'b01) && word[20];
    @(posedge clk);
    instrD <= word;
    flagsE <= t.flags;
    flushE <= flush;
    @(negedge clk);
    checkVal("regSrcD", 32'(regSrcD), 32'(t.regSrc));
    checkVal("immSrcD", 32'(immSrcD), 32'(t.immSrc));
    checkVal("pcWrPendingF", 32'(pcWrPendingF), 32'(t.wr[4]));
    @(posedge clk);
    instrD <= filler;
    flushE <= 1'b0;
    stallE <= stall;
    @(negedge clk);
    checkExecute(t, word, flush, load);
    checkVal("pcWrPendingF", 32'(pcWrPendingF), 32'(t.wr[4] & ~flush));
    @(posedge clk);
    stallE <= 1'b0;
    @(negedge clk);
    if (stall) begin
      checkExecute(t, word, flush, load);  // Held by the stall
      checkVal("previousFlagsE", 32'(previousFlagsE), 32'(modelFlags));
    end
    checkVal("memWriteM", 32'(memWriteM), 32'(t.wr[2]));
    checkVal("regWriteM", 32'(regWriteM), 32'(t.wr[1]));
    checkVal("memtoRegM", 32'(memtoRegM), 32'(load));
    checkVal("pcWrPendingF", 32'(pcWrPendingF), 32'(t.wr[0] | (stall & t.wr[4])));
    @(posedge clk);
    @(negedge clk);
    checkVal("regWriteW", 32'(regWriteW), 32'(t.wr[1]));
    checkVal("memtoRegW", 32'(memtoRegW), 32'(load));
    checkVal("pcSrcW", 32'(pcSrcW), 32'(t.wr[0]));
    if (!flush && word[27:26] == 2'b00 && word[20] && condHolds(word[31:28], modelFlags))
      modelFlags = t.flags;
    checkVal("previousFlagsE", 32'(previousFlagsE), 32'(modelFlags));
    if (!stall)
      checkVal("pcWrPendingF", 32'(pcWrPendingF), 32'd0);
    else
      @(posedge clk);  // Let the repeated Memory/Writeback copy drain
    $display("test %0d word %h %s", idx, word, (errors == errBefore) ? "ok" : "bad");
  endtask

  // Watchdog sized from the table
  initial begin
    wait (tableReady);
    repeat (tests.size() * 6 + 20) @(posedge clk);
    $display("Watchdog expired before all tests finished");
    $display("Simulation FAILED");
    $finish;
  end

  initial begin
    rst    = 1'b1;
    instrD = filler;
    flagsE = '0;
    stallE = 1'b0;
    flushE = 1'b0;
    stallM = 1'b0;
    stallW = 1'b0;
    flushW = 1'b0;
    buildTable();
    tableReady = 1'b1;
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    checkVal("pcWrPendingF", 32'(pcWrPendingF), 32'd0);
    checkVal("regWriteW", 32'(regWriteW), 32'd0);
    for (int i = 0; i < tests.size(); i++)
      runTest(i);
    $display("%0d tests, %0d checks, %0d errors", tests.size(), checks, errors);
    if (errors == 0)
      $display("Simulation PASSED");
    else
      $display("Simulation FAILED");
    $finish;
  end

endmodule

`default_nettype wire
